//--- files.f
lcd_pkg.sv
video_timing_if.sv
line_buffer.sv
video_timing.sv
pixel_colorizer.sv
lcd_top.sv
lcd_properties.sv
tb_lcd.sv

//--- Makefile
# Verilator build and run of the lcd output stage testbench

VERILATOR ?= verilator
TOP       ?= tb_lcd
RTL_TOP   ?= lcd_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_lcd.sv
// testbench for the lcd output stage
// random writes and colour settings against a cycle model of raster and buffer
`timescale 1ns/1ns

module tb_lcd;
	import lcd_pkg::*;

	// small raster, porches as default
	localparam int h_vis = 16;
	localparam int v_vis = 6;
	localparam int h_tot = h_vis + def_hfp + def_hs + def_hbp;
	localparam int v_tot = v_vis + def_vfp + def_vs + def_vbp;

	// mode script, ticks within a line
	localparam int oam_end      = 10;
	localparam int draw_end     = 50;
	localparam int long_line    = 88;
	localparam int reset_ticks  = 4;
	localparam int steady_ticks = 280;
	localparam int first_lines  = 60;
	localparam int vb_frames    = 4;
	localparam int vb_lines     = 3;
	localparam int draw_lines   = 14;
	localparam int run_lines    = 1 + first_lines + vb_frames * (vb_lines + draw_lines);
	// two clocks per tick, every line at most a long one
	localparam int max_cycles   = (reset_ticks + steady_ticks + run_lines * long_line) * 2 + 1000;

	logic   clk;
	logic   reset;
	logic   pix_tick;
	logic   wr_tick;
	logic   wr_en;
	pixel_t wr_data;
	mode_t  mode;
	logic   color_mode;
	logic   tint;
	logic   lcd_on;
	logic   hs;
	logic   vs;
	chan_t  r;
	chan_t  g;
	chan_t  b;

	logic [31:0] lfsr_state = 32'h98e55385;
	int          cycles = 0;

	// model state
	int        h_m;
	int        v_m;
	mode_t     last_h_m;
	mode_t     last_v_m;
	mode_t     prev_mode_m;
	logic      hs_m;
	logic      vs_m;
	logic      blank_m;
	logic      wr_half_m;
	line_idx_t wr_ptr_m;
	line_idx_t rd_ptr_m;
	pixel_t    rd_pixel_m;
	logic      rd_valid_m;
	pixel_t    mem_m [0:511];
	logic      written_m [0:511];

	// activity counts
	int vs_rises = 0;
	int v_resyncs = 0;
	int h_resyncs = 0;
	int colour_checked = 0;
	int mono_checked = 0;

	lcd_top #(.h(h_vis), .v(v_vis)) lcd_top_i (
		.clk (clk), .reset (reset), .pix_tick (pix_tick), .wr_tick (wr_tick),
		.wr_en (wr_en), .wr_data (wr_data), .mode (mode), .color_mode (color_mode),
		.tint (tint), .lcd_on (lcd_on), .hs (hs), .vs (vs), .r (r), .g (g), .b (b)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > max_cycles)
			fail_run($sformatf("timeout, run still going after %0d cycles", cycles));
	end

	// ------------------------------------------------------------
	// failure reporting and compares
	// ------------------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_chan(input string name, input chan_t got, input chan_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	// ------------------------------------------------------------
	// random bits, x^32+x^22+x^2+x+1
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// ------------------------------------------------------------
	// palettes
	// ------------------------------------------------------------
	function automatic chan_t grey_level(input logic [1:0] shade);
		case (shade)
			2'd0: return 6'd63;
			2'd1: return 6'd42;
			2'd2: return 6'd24;
			default: return 6'd0;
		endcase
	endfunction

	// yellow tint as {r, g, b}
	function automatic logic [17:0] tint_level(input logic [1:0] shade);
		case (shade)
			2'd0: return {6'd39, 6'd47, 6'd4};
			2'd1: return {6'd32, 6'd40, 6'd2};
			2'd2: return {6'd12, 6'd25, 6'd12};
			default: return {6'd7, 6'd4, 6'd4};
		endcase
	endfunction

	// ------------------------------------------------------------
	// model, stepped on every rising edge
	// ------------------------------------------------------------
	task automatic step_model();
		logic       vis;
		logic       wrap;
		logic       swap;
		logic [8:0] addr;
		int         h_next;
		int         v_next;
		if (reset) begin
			h_m = 0;
			v_m = 0;
			last_h_m = mode_hblank;
			last_v_m = mode_hblank;
			prev_mode_m = mode_hblank;
			hs_m = 1'b1;
			vs_m = 1'b0;
			blank_m = 1'b1;
			wr_half_m = 1'b0;
			wr_ptr_m = '0;
			rd_ptr_m = '0;
			rd_pixel_m = '0;
			rd_valid_m = 1'b1;
			return;
		end
		if (pix_tick) begin
			vis = (h_m < h_vis) && (v_m < v_vis);
			wrap = (h_m == h_tot - 1);
			// read from the half not being written
			if (vis) begin
				addr = {~wr_half_m, rd_ptr_m};
				rd_pixel_m = mem_m[addr];
				rd_valid_m = written_m[addr];
				rd_ptr_m = rd_ptr_m + 8'd1;
			end else begin
				rd_ptr_m = '0;
			end
			blank_m = !vis;
			if (h_m == h_vis + def_hfp)
				hs_m = 1'b0;
			if (h_m == h_vis + def_hfp + def_hs)
				hs_m = 1'b1;
			if (wrap) begin
				if (v_m == v_vis + def_vfp) begin
					vs_m = 1'b1;
					vs_rises++;
				end
				if (v_m == v_vis + def_vfp + def_vs)
					vs_m = 1'b0;
				v_next = (v_m == v_tot - 1) ? 0 : v_m + 1;
				// end of v-blank parks the count before wrap
				if (mode != mode_vblank && last_v_m == mode_vblank) begin
					v_next = v_tot - resync_lead;
					v_resyncs++;
				end
				last_v_m = mode;
				v_m = v_next;
			end
			h_next = wrap ? 0 : h_m + 1;
			if (mode == mode_oam && last_h_m == mode_hblank) begin
				h_next = 0;
				h_resyncs++;
			end
			last_h_m = mode;
			h_m = h_next;
		end
		// write side, h-blank exit beats a write
		swap = (prev_mode_m == mode_hblank) && (mode != mode_hblank);
		if (wr_tick && wr_en && !swap) begin
			addr = {wr_half_m, wr_ptr_m};
			mem_m[addr] = wr_data;
			written_m[addr] = 1'b1;
			wr_ptr_m = wr_ptr_m + 8'd1;
		end
		if (swap) begin
			wr_half_m = ~wr_half_m;
			wr_ptr_m = '0;
		end
		prev_mode_m = mode;
	endtask

	task automatic check_outputs();
		logic [1:0]  shade;
		logic [17:0] t;
		check_level("hs", hs, hs_m);
		check_level("vs", vs, vs_m);
		if (blank_m) begin
			check_chan("r", r, '0);
			check_chan("g", g, '0);
			check_chan("b", b, '0);
		end else if (!rd_valid_m) begin
			// pixel from a never written entry
		end else if (color_mode) begin
			check_chan("r", r, {rd_pixel_m[4:0], 1'b0});
			check_chan("g", g, {rd_pixel_m[9:5], 1'b0});
			check_chan("b", b, {rd_pixel_m[14:10], 1'b0});
			colour_checked++;
		end else begin
			// display off forces the lightest shade
			shade = lcd_on ? rd_pixel_m[1:0] : 2'd0;
			t = tint ? tint_level(shade) : {3{grey_level(shade)}};
			check_chan("r", r, t[17:12]);
			check_chan("g", g, t[11:6]);
			check_chan("b", b, t[5:0]);
			mono_checked++;
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic drive_inputs(input logic tick, input mode_t m);
		logic [31:0] bits;
		pix_tick = tick;
		wr_tick = 1'b1;
		mode = m;
		take_bits(1, bits);
		wr_en = bits[0];
		take_bits(15, bits);
		wr_data = bits[14:0];
		if (tick) begin
			take_bits(3, bits);
			color_mode = bits[0];
			tint = bits[1];
			lcd_on = bits[2];
		end
	endtask

	// one pixel tick is two clocks, tick high on the first
	task automatic run_tick(input mode_t m);
		drive_inputs(1'b1, m);
		@(posedge clk);
		step_model();
		@(negedge clk);
		check_outputs();
		drive_inputs(1'b0, m);
		@(posedge clk);
		step_model();
		@(negedge clk);
		check_outputs();
	endtask

	// oam, then vram, then h-blank to the end of the line
	task automatic run_line(input int first, input int len);
		mode_t m;
		for (int lp = first; lp < len; lp++) begin
			if (lp < oam_end)
				m = mode_oam;
			else if (lp < draw_end)
				m = mode_vram;
			else
				m = mode_hblank;
			run_tick(m);
		end
	endtask

	initial begin
		for (int i = 0; i < 512; i++)
			written_m[i] = 1'b0;
		reset = 1'b1;
		pix_tick = 1'b0;
		wr_tick = 1'b0;
		wr_en = 1'b0;
		wr_data = '0;
		mode = mode_hblank;
		color_mode = 1'b0;
		tint = 1'b0;
		lcd_on = 1'b0;
		repeat (reset_ticks) run_tick(mode_hblank);
		reset = 1'b0;
		// steady mode, free running raster
		repeat (steady_ticks) run_tick(mode_vram);
		// first h-blank exit lands mid line
		run_line(draw_end, h_tot);
		for (int i = 0; i < first_lines; i++)
			run_line(0, (i % 4 == 3) ? long_line : h_tot);
		for (int f = 0; f < vb_frames; f++) begin
			repeat (vb_lines * h_tot) run_tick(mode_vblank);
			for (int i = 0; i < draw_lines; i++)
				run_line(0, (i % 4 == 3) ? long_line : h_tot);
		end
		if (vs_rises < 2 || v_resyncs < vb_frames || h_resyncs < 10 ||
				colour_checked < 50 || mono_checked < 50) begin
			fail_run($sformatf("too little activity, vs %0d resync %0d/%0d pixels %0d/%0d",
				vs_rises, v_resyncs, h_resyncs, colour_checked, mono_checked));
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

//--- lcd_properties.sv
// sync and blanking assertions for the lcd output stage
// bound into the raster generator and the pixel colouriser
`timescale 1ns/1ns

module lcd_properties #(
	parameter int hs_ticks = lcd_pkg::def_hs
) (
	input logic           clk,
	input logic           reset,
	input logic           pix_tick,
	input logic           visible,
	input lcd_pkg::chan_t r,
	input lcd_pkg::chan_t g,
	input lcd_pkg::chan_t b,
	input logic           hs,
	input logic           vs,
	input logic           vsync_zone
);

	// pixel ticks seen with hs low
	int low_ticks;
	// last registered pixel came from outside the visible area
	logic hidden;

	always_ff @(posedge clk) begin
		if (reset || hs)
			low_ticks <= 0;
		else if (pix_tick)
			low_ticks <= low_ticks + 1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			hidden <= 1'b1;
		else if (pix_tick)
			hidden <= !visible;
	end

	// ------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------
	blank_black: assert property (@(posedge clk) disable iff (reset)
		hidden |-> (r == '0 && g == '0 && b == '0))
		else $error("rgb not zero while blank is set");

	// hs back high exactly after the sync width
	hs_width: assert property (@(posedge clk) disable iff (reset)
		$rose(hs) |-> (low_ticks == hs_ticks))
		else $error("hs low for %0d ticks", low_ticks);

	vs_window: assert property (@(posedge clk) disable iff (reset)
		vs |-> vsync_zone)
		else $error("vs high outside the vertical sync lines");

endmodule

// vs is high on the lines after the sync start up to the sync end
bind video_timing lcd_properties #(.hs_ticks(hs_w)) timing_props_i (
	.clk        (clk),
	.reset      (reset),
	.pix_tick   (pix_tick),
	.visible    (1'b1),
	.r          ('0),
	.g          ('0),
	.b          ('0),
	.hs         (tim.hs),
	.vs         (tim.vs),
	.vsync_zone ((v_cnt > v_sync_on) && (v_cnt <= v_sync_off))
);

bind pixel_colorizer lcd_properties colour_props_i (
	.clk        (clk),
	.reset      (reset),
	.pix_tick   (tim.pix_tick),
	.visible    (tim.visible),
	.r          (r),
	.g          (g),
	.b          (b),
	.hs         (1'b1),
	.vs         (1'b0),
	.vsync_zone (1'b0)
);

//--- lcd_top.sv
// lcd output stage top
// line store and raster generator feeding the pixel colouriser
`timescale 1ns/1ns

module lcd_top #(
	parameter int h    = lcd_pkg::def_h,
	parameter int hfp  = lcd_pkg::def_hfp,
	parameter int hs_w = lcd_pkg::def_hs,
	parameter int hbp  = lcd_pkg::def_hbp,
	parameter int v    = lcd_pkg::def_v,
	parameter int vfp  = lcd_pkg::def_vfp,
	parameter int vs_w = lcd_pkg::def_vs,
	parameter int vbp  = lcd_pkg::def_vbp
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            pix_tick,
	input  logic            wr_tick,
	input  logic            wr_en,
	input  lcd_pkg::pixel_t wr_data,
	input  lcd_pkg::mode_t  mode,
	input  logic            color_mode,
	input  logic            tint,
	input  logic            lcd_on,
	output logic            hs,
	output logic            vs,
	output lcd_pkg::chan_t  r,
	output lcd_pkg::chan_t  g,
	output lcd_pkg::chan_t  b
);
	import lcd_pkg::*;

	pixel_t rd_pixel;

	// shared raster timing
	video_timing_if tim ();

	video_timing #(
		.h(h), .hfp(hfp), .hs_w(hs_w), .hbp(hbp),
		.v(v), .vfp(vfp), .vs_w(vs_w), .vbp(vbp)
	) video_timing_i (
		.clk      (clk),
		.reset    (reset),
		.pix_tick (pix_tick),
		.mode     (mode),
		.tim      (tim)
	);

	line_buffer line_buffer_i (
		.clk      (clk),
		.reset    (reset),
		.wr_tick  (wr_tick),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.mode     (mode),
		.tim      (tim),
		.rd_pixel (rd_pixel)
	);

	pixel_colorizer pixel_colorizer_i (
		.clk        (clk),
		.reset      (reset),
		.rd_pixel   (rd_pixel),
		.color_mode (color_mode),
		.tint       (tint),
		.lcd_on     (lcd_on),
		.tim        (tim),
		.r          (r),
		.g          (g),
		.b          (b)
	);

	// syncs leave straight from their registers
	assign hs = tim.hs;
	assign vs = tim.vs;

endmodule

//--- pixel_colorizer.sv
// pixel colouriser
// blanking plus colour, yellow tint or grey mapping to 6-bit rgb
`timescale 1ns/1ns

module pixel_colorizer (
	input  logic            clk,
	input  logic            reset,
	input  lcd_pkg::pixel_t rd_pixel,
	input  logic            color_mode,
	input  logic            tint,
	input  logic            lcd_on,
	video_timing_if.colour  tim,
	output lcd_pkg::chan_t  r,
	output lcd_pkg::chan_t  g,
	output lcd_pkg::chan_t  b
);
	import lcd_pkg::*;

	logic       blank;
	logic [1:0] shade;
	chan_t      grey;
	chan_t      tint_r;
	chan_t      tint_g;
	chan_t      tint_b;

	// blank lines up with the pixel registered in the line store
	always_ff @(posedge clk) begin
		if (reset)
			blank <= 1'b1;
		else if (tim.pix_tick)
			blank <= !tim.visible;
	end

	// display off shows the lightest shade
	assign shade = lcd_on ? rd_pixel[1:0] : 2'd0;

	// ------------------------------------------------------------
	// mono palettes
	// ------------------------------------------------------------
	always_comb begin
		case (shade)
			2'd0: begin
				grey   = 6'd63;
				tint_r = 6'b100111;
				tint_g = 6'b101111;
				tint_b = 6'b000100;
			end
			2'd1: begin
				grey   = 6'd42;
				tint_r = 6'b100000;
				tint_g = 6'b101000;
				tint_b = 6'b000010;
			end
			2'd2: begin
				grey   = 6'd24;
				tint_r = 6'b001100;
				tint_g = 6'b011001;
				tint_b = 6'b001100;
			end
			default: begin
				grey   = 6'd0;
				tint_r = 6'b000111;
				tint_g = 6'b000100;
				tint_b = 6'b000100;
			end
		endcase
	end

	// output select, blank forces black
	always_comb begin
		if (blank) begin
			r = '0;
			g = '0;
			b = '0;
		end else if (color_mode) begin
			// 5-bit fields widened with a zero lsb
			r = {rd_pixel[4:0], 1'b0};
			g = {rd_pixel[9:5], 1'b0};
			b = {rd_pixel[14:10], 1'b0};
		end else if (tint) begin
			r = tint_r;
			g = tint_g;
			b = tint_b;
		end else begin
			r = grey;
			g = grey;
			b = grey;
		end
	end

endmodule

//--- video_timing.sv
// raster generator
// h and v counters, syncs, and resync to the picture unit mode
`timescale 1ns/1ns

module video_timing #(
	parameter int h    = lcd_pkg::def_h,
	parameter int hfp  = lcd_pkg::def_hfp,
	parameter int hs_w = lcd_pkg::def_hs,
	parameter int hbp  = lcd_pkg::def_hbp,
	parameter int v    = lcd_pkg::def_v,
	parameter int vfp  = lcd_pkg::def_vfp,
	parameter int vs_w = lcd_pkg::def_vs,
	parameter int vbp  = lcd_pkg::def_vbp
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           pix_tick,
	input  lcd_pkg::mode_t mode,
	video_timing_if.source tim
);
	import lcd_pkg::*;

	localparam int h_total = h + hfp + hs_w + hbp;
	localparam int v_total = v + vfp + vs_w + vbp;
	localparam int h_bits  = $clog2(h_total);
	localparam int v_bits  = $clog2(v_total);

	// compare points sized to the counters
	localparam logic [h_bits-1:0] h_last     = h_bits'(h_total - 1);
	localparam logic [h_bits-1:0] h_sync_on  = h_bits'(h + hfp);
	localparam logic [h_bits-1:0] h_sync_off = h_bits'(h + hfp + hs_w);
	localparam logic [v_bits-1:0] v_last     = v_bits'(v_total - 1);
	localparam logic [v_bits-1:0] v_sync_on  = v_bits'(v + vfp);
	localparam logic [v_bits-1:0] v_sync_off = v_bits'(v + vfp + vs_w);
	localparam logic [v_bits-1:0] v_resync   = v_bits'(v_total - resync_lead);

	logic [h_bits-1:0] h_cnt;
	logic [v_bits-1:0] v_cnt;
	mode_t             last_mode_h;
	mode_t             last_mode_v;
	logic              h_wrap;

	assign h_wrap       = (h_cnt == h_last);
	assign tim.pix_tick = pix_tick;
	assign tim.visible  = (h_cnt < h_bits'(h)) && (v_cnt < v_bits'(v));

	// ------------------------------------------------------------
	// horizontal
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt       <= '0;
			tim.hs      <= 1'b1;
			last_mode_h <= mode_hblank;
		end else if (pix_tick) begin
			last_mode_h <= mode;
			if (h_wrap)
				h_cnt <= '0;
			else
				h_cnt <= h_cnt + 1'b1;
			// negative hsync
			if (h_cnt == h_sync_on)
				tim.hs <= 1'b0;
			if (h_cnt == h_sync_off)
				tim.hs <= 1'b1;
			// h-blank into oam restarts the line
			if ((mode == mode_oam) && (last_mode_h == mode_hblank))
				h_cnt <= '0;
		end
	end

	// ------------------------------------------------------------
	// vertical, stepped once per line at h wrap
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			v_cnt       <= '0;
			tim.vs      <= 1'b0;
			last_mode_v <= mode_hblank;
		end else if (pix_tick && h_wrap) begin
			last_mode_v <= mode;
			if (v_cnt == v_last)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
			// positive vsync
			if (v_cnt == v_sync_on)
				tim.vs <= 1'b1;
			if (v_cnt == v_sync_off)
				tim.vs <= 1'b0;
			// end of v-blank, park a few lines before wrap
			if ((mode != mode_vblank) && (last_mode_v == mode_vblank))
				v_cnt <= v_resync;
		end
	end

endmodule

//--- line_buffer.sv
// ping-pong line store
// one half fills from the picture unit while the other is read out
`timescale 1ns/1ns

module line_buffer (
	input  logic           clk,
	input  logic           reset,
	input  logic           wr_tick,
	input  logic           wr_en,
	input  lcd_pkg::pixel_t wr_data,
	input  lcd_pkg::mode_t  mode,
	video_timing_if.buffer  tim,
	output lcd_pkg::pixel_t rd_pixel
);
	import lcd_pkg::*;

	// two halves of 256 pixels, half select on the msb
	pixel_t    mem [0:511];

	logic      wr_half;
	line_idx_t wr_ptr;
	line_idx_t rd_ptr;
	mode_t     prev_mode;
	logic      swap;
	logic      wr_do;

	// leaving h-blank starts a new line
	assign swap  = (prev_mode == mode_hblank) && (mode != mode_hblank);
	// a swap wins over a write in the same clock
	assign wr_do = wr_tick && wr_en && !swap;

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_do) begin
			mem[{wr_half, wr_ptr}] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_half   <= 1'b0;
			wr_ptr    <= '0;
			prev_mode <= mode_hblank;
		end else begin
			// mode tracked every clock, not per pixel tick
			prev_mode <= mode;
			if (swap) begin
				wr_half <= !wr_half;
				wr_ptr  <= '0;
			end else if (wr_do) begin
				// wraps inside the half past 255
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	// reads the half just filled, i.e. the one not being written
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr   <= '0;
			rd_pixel <= '0;
		end else if (tim.pix_tick) begin
			if (tim.visible) begin
				rd_pixel <= mem[{!wr_half, rd_ptr}];
				rd_ptr   <= rd_ptr + 1'b1;
			end else begin
				// rewind for the next visible line
				rd_ptr <= '0;
			end
		end
	end

endmodule

//--- video_timing_if.sv
// raster timing bundle
// pixel enable, visible level and syncs from the raster generator
`timescale 1ns/1ns

interface video_timing_if;

	// display pixel clock enable
	logic pix_tick;
	// both counts inside the visible area
	logic visible;
	// registered syncs, hs active low, vs active high
	logic hs;
	logic vs;

	modport source (output pix_tick, output visible, output hs, output vs);

	// line store only needs the read timing
	modport buffer (input pix_tick, input visible);

	modport colour (input pix_tick, input visible);

endinterface

//--- lcd_pkg.sv
// lcd output stage shared definitions
// pixel and channel types, picture unit modes, default raster
package lcd_pkg;

	// ------------------------------------------------------------
	// data types
	// ------------------------------------------------------------
	// red in [4:0], green in [9:5], blue in [14:10]
	// mono mode keeps its shade in [1:0]
	typedef logic [14:0] pixel_t;

	// one display colour channel
	typedef logic [5:0] chan_t;

	// position within one half of the line store
	typedef logic [7:0] line_idx_t;

	// picture unit mode as seen on its status lines
	typedef enum logic [1:0] {
		mode_hblank = 2'b00,
		mode_vblank = 2'b01,
		mode_oam    = 2'b10,
		mode_vram   = 2'b11
	} mode_t;

	// ------------------------------------------------------------
	// default raster, 228 ticks by 616 lines
	// ------------------------------------------------------------
	localparam int def_h   = 160;
	localparam int def_hfp = 18;
	localparam int def_hs  = 20;
	localparam int def_hbp = 30;
	localparam int def_v   = 576;
	localparam int def_vfp = 2;
	localparam int def_vs  = 2;
	localparam int def_vbp = 36;

	// lines before vertical wrap after v-blank ends
	localparam int resync_lead = 4;

endpackage
